// File: list.f
+incdir+rtl
rtl/state_pkg.sv
rtl/db_pkg.sv
rtl/state_req_arb.sv
rtl/state_element_core.sv
rtl/state_db_mem.sv
rtl/state_element_top.sv
verif/tb_clk_gen.sv
verif/state_element_chk.sv
verif/tb_state_element.sv

// File: Bender.yml
package:
  name: state_element

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/state_pkg.sv
      - rtl/db_pkg.sv
      - rtl/state_req_arb.sv
      - rtl/state_element_core.sv
      - rtl/state_db_mem.sv
      - rtl/state_element_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/tb_clk_gen.sv
      - verif/state_element_chk.sv
      - verif/tb_state_element.sv

// File: verif/tb_state_element.sv
`timescale 1ns/10ps
`include "state_defines.svh"

module tb_state_element
    import state_pkg::*;
    import db_pkg::*;
();

    localparam int NUM_IDS     = 1 << `STATE_ID_WID;
    localparam int CYCLE_LIMIT = 2000;

    logic     clk;
    logic     rst_n;
    logic     update_valid;
    db_addr_t update_id;
    upd_op_t  update_op;
    db_data_t update_data;
    logic     ctrl_req;
    db_addr_t ctrl_id;
    ctrl_op_t ctrl_op;
    db_data_t ctrl_wr_data;
    logic     ctrl_busy;
    logic     ctrl_resp_valid;
    db_data_t ctrl_resp_data;
    logic     init_done;

    // Reference table, kept in issue order
    db_data_t ref_mem [NUM_IDS];

    // Expected responses, oldest first
    db_data_t exp_data_q [$];
    db_addr_t exp_id_q [$];
    string    exp_name_q [$];

    // Control request latched by the DUT and not yet issued
    logic     pend_valid;
    db_addr_t pend_id;
    ctrl_op_t pend_op;
    db_data_t pend_data;

    string  test_name;
    integer seed;
    int     cycle_cnt;
    // Bumped by the bound port checker
    int     chk_fail_cnt;

    tb_clk_gen u_tb_clk_gen (
        .clk (clk)
    );

    state_element_top u_state_element_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .update_valid    (update_valid),
        .update_id       (update_id),
        .update_op       (update_op),
        .update_data     (update_data),
        .ctrl_req        (ctrl_req),
        .ctrl_id         (ctrl_id),
        .ctrl_op         (ctrl_op),
        .ctrl_wr_data    (ctrl_wr_data),
        .ctrl_busy       (ctrl_busy),
        .ctrl_resp_valid (ctrl_resp_valid),
        .ctrl_resp_data  (ctrl_resp_data),
        .init_done       (init_done)
    );

    bind state_element_top state_element_chk u_state_element_chk (
        .clk             (clk),
        .rst_n           (rst_n),
        .ctrl_req        (ctrl_req),
        .ctrl_busy       (ctrl_busy),
        .init_done       (init_done),
        .ctrl_resp_valid (ctrl_resp_valid)
    );

    task automatic end_with_failure();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // Applies one operation and returns the entry's old value
    function automatic db_data_t ref_apply(input logic is_ctrl, input upd_op_t uop,
                                           input ctrl_op_t cop, input db_addr_t id,
                                           input db_data_t data);
        db_data_t old_val;
        old_val = ref_mem[id];
        if (is_ctrl) begin
            case (cop)
                CTRL_WRITE:      ref_mem[id] = data;
                CTRL_READ_CLEAR: ref_mem[id] = '0;
                default:         ;
            endcase
        end else begin
            case (uop)
                // Truncation to the entry width gives the wrap
                UPD_ADD: ref_mem[id] = db_data_t'(old_val + data);
                UPD_OR:  ref_mem[id] = old_val | data;
                default: ref_mem[id] = data;
            endcase
        end
        return old_val;
    endfunction

    function automatic upd_op_t pick_op(input logic [1:0] sel);
        case (sel)
            2'd0:    return UPD_SET;
            2'd1:    return UPD_ADD;
            default: return UPD_OR;
        endcase
    endfunction

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    // Drives one cycle from a falling edge up to the next one
    task automatic step(input logic uv, input db_addr_t uid, input upd_op_t uop,
                        input db_data_t ud, input logic cr, input db_addr_t cid,
                        input ctrl_op_t cop, input db_data_t cd);
        update_valid = uv;
        update_id    = uid;
        update_op    = uop;
        update_data  = ud;
        ctrl_req     = cr;
        ctrl_id      = cid;
        ctrl_op      = cop;
        ctrl_wr_data = cd;
        if (cr) begin
            pend_valid = 1'b1;
            pend_id    = cid;
            pend_op    = cop;
            pend_data  = cd;
        end
        // An update strobed now goes out next cycle ahead of a held request
        if (uv) begin
            void'(ref_apply(1'b0, uop, CTRL_READ, uid, ud));
        end
        // Held request takes the slot after the first strobe-free cycle
        if (pend_valid && !uv) begin
            exp_data_q.push_back(ref_apply(1'b1, UPD_SET, pend_op, pend_id, pend_data));
            exp_id_q.push_back(pend_id);
            exp_name_q.push_back(test_name);
            pend_valid = 1'b0;
        end
        @(negedge clk);
    endtask

    // Strobes on both ports that the DUT must drop before init_done
    task automatic drive_ignored_strobes();
        update_valid = 1'b1;
        update_id    = 6'd7;
        update_op    = UPD_SET;
        update_data  = 16'hDEAD;
        ctrl_req     = 1'b1;
        ctrl_id      = 6'd7;
        ctrl_op      = CTRL_WRITE;
        ctrl_wr_data = 16'hBEEF;
        @(negedge clk);
    endtask

    task automatic idle_cycle();
        step(1'b0, '0, UPD_SET, '0, 1'b0, '0, CTRL_READ, '0);
    endtask

    task automatic send_update(input db_addr_t id, input upd_op_t op, input db_data_t data);
        step(1'b1, id, op, data, 1'b0, '0, CTRL_READ, '0);
    endtask

    task automatic send_ctrl(input db_addr_t id, input ctrl_op_t op, input db_data_t data);
        while (ctrl_busy) begin
            idle_cycle();
        end
        step(1'b0, '0, UPD_SET, '0, 1'b1, id, op, data);
    endtask

    task automatic read_all_ids();
        int i;
        for (i = 0; i < NUM_IDS; i++) begin
            send_ctrl(db_addr_t'(i), CTRL_READ, '0);
        end
    endtask

    task automatic drain_responses();
        while (pend_valid || exp_data_q.size() != 0) begin
            idle_cycle();
        end
    endtask

    // ----------------------------------------
    // Response comparison
    // ----------------------------------------
    always @(negedge clk) begin : compare_resp
        db_data_t exp_data;
        db_addr_t exp_id;
        string    exp_name;
        if (rst_n && ctrl_resp_valid) begin
            assert (exp_data_q.size() != 0) else begin
                $display("ERROR: control response arrived with no request outstanding");
                end_with_failure();
            end
            exp_data = exp_data_q.pop_front();
            exp_id   = exp_id_q.pop_front();
            exp_name = exp_name_q.pop_front();
            assert (ctrl_resp_data === exp_data) else begin
                $display("FAIL %s: id %0d expected 0x%04h actual 0x%04h",
                         exp_name, exp_id, exp_data, ctrl_resp_data);
                end_with_failure();
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("ERROR: timeout after %0d cycles, the DUT stopped making progress",
                     cycle_cnt);
            end_with_failure();
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin : stimulus
        db_addr_t    burst_id;
        logic [31:0] r;
        int          i;
        int          lat;
        int          wait_cycles;

        seed         = 78;
        cycle_cnt    = 0;
        chk_fail_cnt = 0;
        pend_valid   = 1'b0;
        test_name    = "reset";
        for (i = 0; i < NUM_IDS; i++) begin
            ref_mem[i] = '0;
        end
        rst_n        = 1'b0;
        update_valid = 1'b0;
        update_id    = '0;
        update_op    = UPD_SET;
        update_data  = '0;
        ctrl_req     = 1'b0;
        ctrl_id      = '0;
        ctrl_op      = CTRL_READ;
        ctrl_wr_data = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // Sweep must leave every entry at zero
        test_name   = "init";
        wait_cycles = 0;
        while (!init_done) begin
            drive_ignored_strobes();
            wait_cycles++;
        end
        // One entry per cycle, so the sweep cannot finish sooner
        assert (wait_cycles >= NUM_IDS) else begin
            $display("FAIL %s: init_done delay expected >= %0d actual %0d",
                     test_name, NUM_IDS, wait_cycles);
            end_with_failure();
        end
        read_all_ids();
        drain_responses();

        // Back-to-back updates with same-ID runs to exercise forwarding
        test_name = "datapath";
        burst_id  = '0;
        for (i = 0; i < 200; i++) begin
            r = $random(seed);
            if (r[0]) begin
                burst_id = db_addr_t'($random(seed));
            end
            send_update(burst_id, pick_op(r[2:1]), db_data_t'($random(seed)));
        end
        repeat (4) idle_cycle();
        read_all_ids();
        drain_responses();

        test_name = "ctrl_write_clear";
        send_ctrl(6'd5, CTRL_WRITE, 16'hA5C3);
        send_ctrl(6'd5, CTRL_READ, '0);
        send_ctrl(6'd5, CTRL_READ_CLEAR, '0);
        send_ctrl(6'd5, CTRL_READ, '0);
        send_ctrl(6'd63, CTRL_WRITE, 16'hFFFF);
        send_ctrl(6'd63, CTRL_READ_CLEAR, '0);
        send_ctrl(6'd63, CTRL_READ, '0);
        drain_responses();

        // Control request starved by a continuous update stream
        test_name = "contention";
        send_update(6'd0, UPD_SET, 16'h1234);
        for (i = 0; i < 24; i++) begin
            r = $random(seed);
            // ID 0 stays reserved for the control request
            burst_id = (r[5:0] == 6'd0) ? 6'd1 : r[5:0];
            step(1'b1, burst_id, pick_op(r[7:6]), r[31:16],
                 (i == 4), 6'd0, CTRL_READ_CLEAR, '0);
        end
        repeat (4) idle_cycle();
        read_all_ids();
        drain_responses();

        // Quiet pipeline gives a fixed response time
        test_name = "latency";
        send_ctrl(6'd9, CTRL_READ, '0);
        lat = 1;
        while (!ctrl_resp_valid) begin
            // Busy only while the request waits for its issue slot
            assert (ctrl_busy === (lat == 1)) else begin
                $display("FAIL %s: ctrl_busy expected %0b actual %0b",
                         test_name, (lat == 1), ctrl_busy);
                end_with_failure();
            end
            idle_cycle();
            lat++;
        end
        assert (lat == 3) else begin
            $display("FAIL %s: expected 3 actual %0d", test_name, lat);
            end_with_failure();
        end
        drain_responses();

        repeat (2) idle_cycle();
        if (chk_fail_cnt == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("ERROR: %0d port checker assertions failed", chk_fail_cnt);
            end_with_failure();
        end
    end

endmodule : tb_state_element

// File: verif/state_element_chk.sv
`timescale 1ns/10ps

module state_element_chk (
    input logic clk,
    input logic rst_n,
    input logic ctrl_req,
    input logic ctrl_busy,
    input logic init_done,
    input logic ctrl_resp_valid
);

    // ----------------------------------------
    // Control port protocol
    // ----------------------------------------
    // Only one request may be outstanding
    a_no_req_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) ctrl_req |-> !ctrl_busy
    ) else begin
        $error("ctrl_req pulsed while ctrl_busy was high");
        tb_state_element.chk_fail_cnt++;
    end

    // Responses only once the table is swept
    a_no_resp_before_init: assert property (
        @(posedge clk) disable iff (!rst_n) ctrl_resp_valid |-> init_done
    ) else begin
        $error("ctrl_resp_valid pulsed before init_done");
        tb_state_element.chk_fail_cnt++;
    end

    // ----------------------------------------
    // Init sweep
    // ----------------------------------------
    // Sticky once raised
    a_init_done_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) init_done |=> init_done
    ) else begin
        $error("init_done fell after rising");
        tb_state_element.chk_fail_cnt++;
    end

endmodule : state_element_chk

// File: verif/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk
);

    // 100 ns period
    localparam time HALF_PERIOD = 50ns;

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule : tb_clk_gen

// File: rtl/state_element_top.sv
`timescale 1ns/10ps
`include "state_defines.svh"

module state_element_top
    import state_pkg::*;
    import db_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,

    // Datapath update port
    input  logic                       update_valid,
    input  logic [`STATE_ID_WID-1:0]   update_id,
    input  upd_op_t                    update_op,
    input  logic [`STATE_DATA_WID-1:0] update_data,

    // Control-plane port
    input  logic                       ctrl_req,
    input  logic [`STATE_ID_WID-1:0]   ctrl_id,
    input  ctrl_op_t                   ctrl_op,
    input  logic [`STATE_DATA_WID-1:0] ctrl_wr_data,
    output logic                       ctrl_busy,
    output logic                       ctrl_resp_valid,
    output db_data_t                   ctrl_resp_data,

    output logic                       init_done
);

    // ----------------------------------------
    // Issue path, arbiter to core
    // ----------------------------------------
    logic                       iss_valid;
    logic [`STATE_ID_WID-1:0]   iss_id;
    op_kind_t                   iss_kind;
    logic [`STATE_DATA_WID-1:0] iss_data;
    logic                       iss_is_ctrl;

    // Storage ports, core to memory
    logic     rd_en;
    db_addr_t rd_addr;
    db_data_t rd_data;
    logic     wr_en;
    db_addr_t wr_addr;
    db_data_t wr_data;

    state_req_arb u_state_req_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .init_done    (init_done),
        .update_valid (update_valid),
        .update_id    (update_id),
        .update_op    (update_op),
        .update_data  (update_data),
        .ctrl_req     (ctrl_req),
        .ctrl_id      (ctrl_id),
        .ctrl_op      (ctrl_op),
        .ctrl_wr_data (ctrl_wr_data),
        .ctrl_busy    (ctrl_busy),
        .iss_valid    (iss_valid),
        .iss_id       (iss_id),
        .iss_kind     (iss_kind),
        .iss_data     (iss_data),
        .iss_is_ctrl  (iss_is_ctrl)
    );

    state_element_core u_state_element_core (
        .clk             (clk),
        .rst_n           (rst_n),
        .iss_valid       (iss_valid),
        .iss_id          (iss_id),
        .iss_kind        (iss_kind),
        .iss_data        (iss_data),
        .iss_is_ctrl     (iss_is_ctrl),
        .rd_en           (rd_en),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .ctrl_resp_valid (ctrl_resp_valid),
        .ctrl_resp_data  (ctrl_resp_data)
    );

    // Storage also owns the init sweep
    state_db_mem u_state_db_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_data   (rd_data),
        .init_done (init_done)
    );

endmodule : state_element_top

// File: rtl/state_db_mem.sv
`timescale 1ns/10ps
`include "state_defines.svh"

module state_db_mem
    import db_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     rd_en,
    input  db_addr_t rd_addr,
    input  logic     wr_en,
    input  db_addr_t wr_addr,
    input  db_data_t wr_data,
    output db_data_t rd_data,
    output logic     init_done
);

    localparam int DEPTH = 1 << `STATE_ID_WID;

    // Entry storage
    db_data_t mem [DEPTH];

    db_init_t init_state;
    db_addr_t sweep_addr;

    // Merged write port
    logic     mem_we;
    db_addr_t mem_waddr;
    db_data_t mem_wdata;

    // ----------------------------------------
    // Init sweep
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_state <= INIT_IDLE;
            sweep_addr <= '0;
        end else begin
            case (init_state)
                INIT_IDLE: begin
                    init_state <= INIT_SWEEP;
                    sweep_addr <= '0;
                end
                INIT_SWEEP: begin
                    // One entry per cycle, 64 cycles in total
                    sweep_addr <= sweep_addr + 1'b1;
                    if (sweep_addr == db_addr_t'(DEPTH - 1)) begin
                        init_state <= INIT_DONE;
                    end
                end
                default: init_state <= INIT_DONE;
            endcase
        end
    end

    assign init_done = (init_state == INIT_DONE);

    // Sweep owns the write port until it finishes
    assign mem_we    = (init_state == INIT_SWEEP) || wr_en;
    assign mem_waddr = (init_state == INIT_SWEEP) ? sweep_addr : wr_addr;
    assign mem_wdata = (init_state == INIT_SWEEP) ? '0 : wr_data;

    // ----------------------------------------
    // Array access
    // ----------------------------------------
    // Read returns pre-write contents on a same-cycle collision
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule : state_db_mem

// File: rtl/state_element_core.sv
`timescale 1ns/10ps
`include "state_defines.svh"

module state_element_core
    import state_pkg::*;
    import db_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,

    // Issue from the arbiter
    input  logic                       iss_valid,
    input  logic [`STATE_ID_WID-1:0]   iss_id,
    input  op_kind_t                   iss_kind,
    input  logic [`STATE_DATA_WID-1:0] iss_data,
    input  logic                       iss_is_ctrl,

    // Storage read port, data arrives one cycle after rd_en
    output logic                       rd_en,
    output db_addr_t                   rd_addr,
    input  db_data_t                   rd_data,

    // Storage write port
    output logic                       wr_en,
    output db_addr_t                   wr_addr,
    output db_data_t                   wr_data,

    // Control-plane response
    output logic                       ctrl_resp_valid,
    output db_data_t                   ctrl_resp_data
);

    // ----------------------------------------
    // Stage 1 registers
    // ----------------------------------------
    logic     s1_valid;
    logic     s1_is_ctrl;
    db_addr_t s1_id;
    op_kind_t s1_kind;
    db_data_t s1_data;

    // Forwarding info captured at issue time
    logic     s1_fwd;
    db_data_t s1_fwd_data;

    // Stage 1 datapath
    db_data_t s1_old;
    db_data_t s1_new;

    // Stage 0 match against the op now in stage 1
    logic     s0_hit;

    // ----------------------------------------
    // Stage 0, launch the storage read
    // ----------------------------------------
    assign rd_en   = iss_valid;
    assign rd_addr = iss_id;

    // The op ahead writes at the end of this cycle, so the storage read
    // misses it and its result has to be carried along instead
    assign s0_hit = s1_valid && (s1_id == iss_id);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid        <= 1'b0;
            s1_is_ctrl      <= 1'b0;
            ctrl_resp_valid <= 1'b0;
        end else begin
            s1_valid        <= iss_valid;
            s1_is_ctrl      <= iss_valid && iss_is_ctrl;
            ctrl_resp_valid <= s1_valid && s1_is_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            s1_id       <= iss_id;
            s1_kind     <= iss_kind;
            s1_data     <= iss_data;
            s1_fwd      <= s0_hit;
            s1_fwd_data <= s1_new;
        end
        // Old value goes back to the control plane
        if (s1_valid && s1_is_ctrl) begin
            ctrl_resp_data <= s1_old;
        end
    end

    // ----------------------------------------
    // Stage 1, modify
    // ----------------------------------------
    assign s1_old = s1_fwd ? s1_fwd_data : rd_data;

    always_comb begin
        case (s1_kind)
            OP_SET:   s1_new = s1_data;
            // Wraps modulo 2^16
            OP_ADD:   s1_new = s1_old + s1_data;
            OP_OR:    s1_new = s1_old | s1_data;
            OP_CLEAR: s1_new = '0;
            // READ leaves the entry as it was
            default:  s1_new = s1_old;
        endcase
    end

    // ----------------------------------------
    // Stage 1, write back
    // ----------------------------------------
    // READ has nothing to store
    assign wr_en   = s1_valid && (s1_kind != OP_READ);
    assign wr_addr = s1_id;
    assign wr_data = s1_new;

endmodule : state_element_core

// File: rtl/state_req_arb.sv
`timescale 1ns/10ps
`include "state_defines.svh"

module state_req_arb
    import state_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       init_done,
    input  logic                       update_valid,
    input  logic [`STATE_ID_WID-1:0]   update_id,
    input  upd_op_t                    update_op,
    input  logic [`STATE_DATA_WID-1:0] update_data,
    input  logic                       ctrl_req,
    input  logic [`STATE_ID_WID-1:0]   ctrl_id,
    input  ctrl_op_t                   ctrl_op,
    input  logic [`STATE_DATA_WID-1:0] ctrl_wr_data,
    output logic                       ctrl_busy,
    output logic                       iss_valid,
    output logic [`STATE_ID_WID-1:0]   iss_id,
    output op_kind_t                   iss_kind,
    output logic [`STATE_DATA_WID-1:0] iss_data,
    output logic                       iss_is_ctrl
);

    // ----------------------------------------
    // Opcode mapping
    // ----------------------------------------
    function automatic op_kind_t upd_to_kind(input upd_op_t op);
        case (op)
            UPD_ADD: return OP_ADD;
            UPD_OR:  return OP_OR;
            default: return OP_SET;
        endcase
    endfunction

    // Control write becomes a plain SET
    function automatic op_kind_t ctrl_to_kind(input ctrl_op_t op);
        case (op)
            CTRL_WRITE:      return OP_SET;
            CTRL_READ_CLEAR: return OP_CLEAR;
            default:         return OP_READ;
        endcase
    endfunction

    // Registered datapath update
    logic                       upd_valid_q;
    logic [`STATE_ID_WID-1:0]   upd_id_q;
    op_kind_t                   upd_kind_q;
    logic [`STATE_DATA_WID-1:0] upd_data_q;

    // One-entry control hold register
    logic                       hold_valid;
    logic [`STATE_ID_WID-1:0]   hold_id;
    op_kind_t                   hold_kind;
    logic [`STATE_DATA_WID-1:0] hold_data;

    logic upd_accept;
    logic ctrl_accept;
    logic hold_issue;

    // Nothing is taken before the table is cleared
    assign upd_accept  = update_valid && init_done;
    assign ctrl_accept = ctrl_req && init_done && !hold_valid;

    // Held request only goes out when the datapath leaves the slot empty
    assign hold_issue = hold_valid && !upd_valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            upd_valid_q <= 1'b0;
            hold_valid  <= 1'b0;
        end else begin
            upd_valid_q <= upd_accept;
            if (ctrl_accept) begin
                hold_valid <= 1'b1;
            end else if (hold_issue) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd_accept) begin
            upd_id_q   <= update_id;
            upd_kind_q <= upd_to_kind(update_op);
            upd_data_q <= update_data;
        end
        if (ctrl_accept) begin
            hold_id   <= ctrl_id;
            hold_kind <= ctrl_to_kind(ctrl_op);
            // Read-type requests carry no payload
            hold_data <= (ctrl_op == CTRL_WRITE) ? ctrl_wr_data : '0;
        end
    end

    // ----------------------------------------
    // Issue select, datapath first
    // ----------------------------------------
    assign iss_valid   = upd_valid_q || hold_valid;
    assign iss_is_ctrl = hold_issue;
    assign iss_id      = upd_valid_q ? upd_id_q   : hold_id;
    assign iss_kind    = upd_valid_q ? upd_kind_q : hold_kind;
    assign iss_data    = upd_valid_q ? upd_data_q : hold_data;

    // Busy until the cycle after the held request issues
    assign ctrl_busy = hold_valid;

endmodule : state_req_arb

// File: rtl/db_pkg.sv
`include "state_defines.svh"

package db_pkg;

    // Storage address, one per state ID
    typedef logic [`STATE_ID_WID-1:0] db_addr_t;

    // Storage word
    typedef logic [`STATE_DATA_WID-1:0] db_data_t;

    // Init sweep progress
    // IDLE right after reset, SWEEP while zeroing, DONE forever after
    typedef enum logic [1:0] {
        INIT_IDLE  = 2'd0,
        INIT_SWEEP = 2'd1,
        INIT_DONE  = 2'd2
    } db_init_t;

endpackage : db_pkg

// File: rtl/state_pkg.sv
`include "state_defines.svh"

package state_pkg;

    // Datapath update opcode, carried with update_valid
    typedef enum logic [1:0] {
        UPD_SET = 2'd0,
        UPD_ADD = 2'd1,
        UPD_OR  = 2'd2
    } upd_op_t;

    // Control-plane opcode, carried with ctrl_req
    typedef enum logic [1:0] {
        CTRL_READ       = 2'd0,
        CTRL_WRITE      = 2'd1,
        CTRL_READ_CLEAR = 2'd2
    } ctrl_op_t;

    // Unified operation as seen by the RMW pipeline
    typedef enum logic [2:0] {
        OP_SET   = 3'd0,
        OP_ADD   = 3'd1,
        OP_OR    = 3'd2,
        OP_READ  = 3'd3,
        OP_CLEAR = 3'd4
    } op_kind_t;

endpackage : state_pkg

// File: rtl/state_defines.svh
`ifndef STATE_DEFINES_SVH
`define STATE_DEFINES_SVH

// Width of an entry ID
// 6 bits gives a 64-entry table
`define STATE_ID_WID 6

// Width of one stored state entry
`define STATE_DATA_WID 16

`endif
